// File: src/mult_geom_pkg.sv
package mult_geom_pkg;

    // ======================================================================
    // Top level operand and product geometry
    // ======================================================================
    localparam int OPERAND_W    = 8;
    localparam int PRODUCT_W    = 2 * OPERAND_W;
    localparam int MULT_LATENCY = 2;                   // Input register plus output register

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // ======================================================================
    // Recursive levels, low part width at each split
    // ======================================================================
    localparam int SPLIT_8 = 2;                        // 8 = 6 + 2
    localparam int SPLIT_6 = 1;                        // 6 = 5 + 1
    localparam int SPLIT_5 = 2;                        // 5 = 3 + 2

    localparam int OP6_W = OPERAND_W - SPLIT_8;
    localparam int OP5_W = OP6_W - SPLIT_6;
    localparam int OP3_W = OP5_W - SPLIT_5;

    typedef logic [OP6_W-1:0]   op6_t;
    typedef logic [OP5_W-1:0]   op5_t;
    typedef logic [2*OP6_W-1:0] prod6_t;              // 12 bit product of the 6x6 block
    typedef logic [2*OP5_W-1:0] prod5_t;              // 10 bit product of the 5x5 block

endpackage

// File: src/approx_cfg_pkg.sv
package approx_cfg_pkg;

    // ======================================================================
    // Number of OR-approximated low bits per adder
    // ======================================================================

    // 8x8 level, cross adder is 8 bit and final adder is 14 bit
    localparam int L8_CROSS_APPROX = 0;
    localparam int L8_SUM_APPROX   = 5;

    // 6x6 level, cross adder is 5 bit and final adder is 11 bit
    localparam int L6_CROSS_APPROX = 0;
    localparam int L6_SUM_APPROX   = 5;

    // 5x5 level, cross adder is 5 bit and final adder is 8 bit
    localparam int L5_CROSS_APPROX = 0;
    localparam int L5_SUM_APPROX   = 2;

    // A zero count makes the adder fully exact, which is what every cross
    // adder uses since the cross products carry the most weight at each
    // level relative to their width

endpackage

// File: src/lower_or_adder.sv
`timescale 1ns/1ps

// Approximate adder: low zone is a plain OR, upper zone is an exact sum
// that receives no carry from the low zone
module lower_or_adder #(
    parameter int WIDTH_A     = 8,
    parameter int WIDTH_B     = 8,
    parameter int APPROX_BITS = 0
) (
    input  logic [WIDTH_A-1:0]                               x,
    input  logic [WIDTH_B-1:0]                               y,
    output logic [((WIDTH_A > WIDTH_B) ? WIDTH_A : WIDTH_B):0] sum
);

    localparam int MAX_W   = (WIDTH_A > WIDTH_B) ? WIDTH_A : WIDTH_B;
    localparam int UPPER_W = MAX_W - APPROX_BITS;

    logic [MAX_W-1:0] x_ext;
    logic [MAX_W-1:0] y_ext;
    logic [UPPER_W:0] upper_sum;                       // Carry out lands in the top bit

    assign x_ext = MAX_W'(x);                          // Zero extend the narrower operand
    assign y_ext = MAX_W'(y);

    assign upper_sum = {1'b0, x_ext[MAX_W-1:APPROX_BITS]}
                     + {1'b0, y_ext[MAX_W-1:APPROX_BITS]};

    // ======================================================================
    // Result assembly
    // ======================================================================
    if (APPROX_BITS == 0) begin : g_exact
        assign sum = upper_sum;                        // Whole width is exact
    end else begin : g_approx
        logic [APPROX_BITS-1:0] lower_or;

        assign lower_or = x_ext[APPROX_BITS-1:0] | y_ext[APPROX_BITS-1:0];
        assign sum      = {upper_sum, lower_or};
    end

endmodule

// File: src/exact_sub_mult.sv
`timescale 1ns/1ps

module exact_sub_mult #(
    parameter int WIDTH_A = 3,
    parameter int WIDTH_B = 3
) (
    input  logic [WIDTH_A-1:0]         x,
    input  logic [WIDTH_B-1:0]         y,
    output logic [WIDTH_A+WIDTH_B-1:0] prod
);

    localparam int PROD_W = WIDTH_A + WIDTH_B;

    logic [WIDTH_A-1:0] pp_row [WIDTH_B];             // One AND row per multiplier bit
    logic [PROD_W-1:0]  pp_shift [WIDTH_B];

    for (genvar i = 0; i < WIDTH_B; i++) begin : g_rows
        assign pp_row[i]   = x & {WIDTH_A{y[i]}};
        assign pp_shift[i] = PROD_W'(pp_row[i]) << i;  // Align row to its weight
    end

    // ======================================================================
    // Shift-add accumulation of the partial products
    // ======================================================================
    always_comb begin : p_accum
        logic [PROD_W-1:0] acc;

        acc = '0;
        for (int i = 0; i < WIDTH_B; i++) begin
            acc = acc + pp_shift[i];                   // Never overflows PROD_W
        end
        prod = acc;
    end

endmodule

// File: src/recursive_mult_5x5.sv
`timescale 1ns/1ps

module recursive_mult_5x5
    import mult_geom_pkg::*;
    import approx_cfg_pkg::*;
(
    input  op5_t   a,
    input  op5_t   b,
    output prod5_t p
);

    logic [OP3_W-1:0]   a_h;
    logic [OP3_W-1:0]   b_h;
    logic [SPLIT_5-1:0] a_l;
    logic [SPLIT_5-1:0] b_l;

    assign a_h = a[OP5_W-1:SPLIT_5];
    assign b_h = b[OP5_W-1:SPLIT_5];
    assign a_l = a[SPLIT_5-1:0];
    assign b_l = b[SPLIT_5-1:0];

    // Leaf sub-products
    logic [2*OP3_W-1:0]       p_hh;
    logic [OP3_W+SPLIT_5-1:0] p_hl;
    logic [OP3_W+SPLIT_5-1:0] p_lh;
    logic [2*SPLIT_5-1:0]     p_ll;

    exact_sub_mult #(.WIDTH_A(OP3_W),   .WIDTH_B(OP3_W))   u_mult_hh (.x(a_h), .y(b_h), .prod(p_hh));
    exact_sub_mult #(.WIDTH_A(OP3_W),   .WIDTH_B(SPLIT_5)) u_mult_hl (.x(a_h), .y(b_l), .prod(p_hl));
    exact_sub_mult #(.WIDTH_A(SPLIT_5), .WIDTH_B(OP3_W))   u_mult_lh (.x(a_l), .y(b_h), .prod(p_lh));
    exact_sub_mult #(.WIDTH_A(SPLIT_5), .WIDTH_B(SPLIT_5)) u_mult_ll (.x(a_l), .y(b_l), .prod(p_ll));

    // ======================================================================
    // Sum tree
    // ======================================================================
    logic [2*OP3_W+SPLIT_5-1:0] operand1;              // High product over upper half of p_ll
    logic [OP3_W+SPLIT_5:0]     operand2;              // Exact sum of the cross products
    logic [2*OP3_W+SPLIT_5:0]   sum_out;

    assign operand1 = {p_hh, p_ll[2*SPLIT_5-1:SPLIT_5]};

    lower_or_adder #(
        .WIDTH_A     (OP3_W + SPLIT_5),
        .WIDTH_B     (OP3_W + SPLIT_5),
        .APPROX_BITS (L5_CROSS_APPROX)
    ) u_cross_add (
        .x   (p_hl),
        .y   (p_lh),
        .sum (operand2)
    );

    lower_or_adder #(
        .WIDTH_A     (2*OP3_W + SPLIT_5),
        .WIDTH_B     (OP3_W + SPLIT_5 + 1),
        .APPROX_BITS (L5_SUM_APPROX)
    ) u_final_add (
        .x   (operand1),
        .y   (operand2),
        .sum (sum_out)
    );

    // Low half of p_ll bypasses the adders, carry out of the final adder is dropped
    assign p = {sum_out[2*OP3_W+SPLIT_5-1:0], p_ll[SPLIT_5-1:0]};

endmodule

// File: src/recursive_mult_6x6.sv
`timescale 1ns/1ps

module recursive_mult_6x6
    import mult_geom_pkg::*;
    import approx_cfg_pkg::*;
(
    input  op6_t   a,
    input  op6_t   b,
    output prod6_t p
);

    op5_t               a_h;
    op5_t               b_h;
    logic [SPLIT_6-1:0] a_l;
    logic [SPLIT_6-1:0] b_l;

    assign a_h = a[OP6_W-1:SPLIT_6];
    assign b_h = b[OP6_W-1:SPLIT_6];
    assign a_l = a[SPLIT_6-1:0];
    assign b_l = b[SPLIT_6-1:0];

    prod5_t                   p_hh;
    logic [OP5_W+SPLIT_6-1:0] p_hl;
    logic [OP5_W+SPLIT_6-1:0] p_lh;
    logic [2*SPLIT_6-1:0]     p_ll;

    recursive_mult_5x5 u_mult_hh (.a(a_h), .b(b_h), .p(p_hh));

    exact_sub_mult #(.WIDTH_A(OP5_W),   .WIDTH_B(SPLIT_6)) u_mult_hl (.x(a_h), .y(b_l), .prod(p_hl));
    exact_sub_mult #(.WIDTH_A(SPLIT_6), .WIDTH_B(OP5_W))   u_mult_lh (.x(a_l), .y(b_h), .prod(p_lh));
    exact_sub_mult #(.WIDTH_A(SPLIT_6), .WIDTH_B(SPLIT_6)) u_mult_ll (.x(a_l), .y(b_l), .prod(p_ll));

    // ======================================================================
    // Sum tree
    // ======================================================================
    logic [2*OP5_W:0]  operand1;
    logic [OP5_W:0]    operand2;
    logic [2*OP5_W+1:0] sum_out;

    // A 1x1 product is at most 1, so nothing sits above its single low bit
    assign operand1 = {p_hh, 1'b0};

    // Cross products fit in OP5_W bits since one factor is a single bit
    lower_or_adder #(
        .WIDTH_A     (OP5_W),
        .WIDTH_B     (OP5_W),
        .APPROX_BITS (L6_CROSS_APPROX)
    ) u_cross_add (
        .x   (p_hl[OP5_W-1:0]),
        .y   (p_lh[OP5_W-1:0]),
        .sum (operand2)
    );

    lower_or_adder #(
        .WIDTH_A     (2*OP5_W + 1),
        .WIDTH_B     (OP5_W + 1),
        .APPROX_BITS (L6_SUM_APPROX)
    ) u_final_add (
        .x   (operand1),
        .y   (operand2),
        .sum (sum_out)
    );

    assign p = {sum_out[2*OP5_W:0], p_ll[0]};        // Top carry is dropped

endmodule

// File: src/approx_mult_8x8.sv
`timescale 1ns/1ps

module approx_mult_8x8
    import mult_geom_pkg::*;
    import approx_cfg_pkg::*;
(
    input  operand_t a,
    input  operand_t b,
    output product_t p
);

    // ======================================================================
    // Operand split, high part 6 bits and low part 2 bits
    // ======================================================================
    op6_t               a_h;
    op6_t               b_h;
    logic [SPLIT_8-1:0] a_l;
    logic [SPLIT_8-1:0] b_l;

    assign a_h = a[OPERAND_W-1:SPLIT_8];
    assign b_h = b[OPERAND_W-1:SPLIT_8];
    assign a_l = a[SPLIT_8-1:0];
    assign b_l = b[SPLIT_8-1:0];

    // ======================================================================
    // Sub-products
    // ======================================================================
    prod6_t                   p_hh;                    // Approximate, from the recursion
    logic [OP6_W+SPLIT_8-1:0] p_hl;
    logic [OP6_W+SPLIT_8-1:0] p_lh;
    logic [2*SPLIT_8-1:0]     p_ll;

    recursive_mult_6x6 u_mult_hh (
        .a (a_h),
        .b (b_h),
        .p (p_hh)
    );

    exact_sub_mult #(.WIDTH_A(OP6_W),   .WIDTH_B(SPLIT_8)) u_mult_hl (.x(a_h), .y(b_l), .prod(p_hl));
    exact_sub_mult #(.WIDTH_A(SPLIT_8), .WIDTH_B(OP6_W))   u_mult_lh (.x(a_l), .y(b_h), .prod(p_lh));
    exact_sub_mult #(.WIDTH_A(SPLIT_8), .WIDTH_B(SPLIT_8)) u_mult_ll (.x(a_l), .y(b_l), .prod(p_ll));

    // ======================================================================
    // Sum tree
    // ======================================================================
    logic [2*OP6_W+SPLIT_8-1:0] operand1;
    logic [OP6_W+SPLIT_8:0]     operand2;
    logic [2*OP6_W+SPLIT_8:0]   sum_out;

    assign operand1 = {p_hh, p_ll[2*SPLIT_8-1:SPLIT_8]};

    lower_or_adder #(
        .WIDTH_A     (OP6_W + SPLIT_8),
        .WIDTH_B     (OP6_W + SPLIT_8),
        .APPROX_BITS (L8_CROSS_APPROX)
    ) u_cross_add (
        .x   (p_hl),
        .y   (p_lh),
        .sum (operand2)
    );

    lower_or_adder #(
        .WIDTH_A     (2*OP6_W + SPLIT_8),
        .WIDTH_B     (OP6_W + SPLIT_8 + 1),
        .APPROX_BITS (L8_SUM_APPROX)
    ) u_final_add (
        .x   (operand1),
        .y   (operand2),
        .sum (sum_out)
    );

    // Bits 1:0 of the product are exact, taken straight from p_ll
    assign p = {sum_out[2*OP6_W+SPLIT_8-1:0], p_ll[SPLIT_8-1:0]};

endmodule

// File: src/approx_mult_top.sv
`timescale 1ns/1ps

// Registered wrapper, MULT_LATENCY register stages from in_valid to out_valid
module approx_mult_top
    import mult_geom_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    output product_t p
);

    operand_t a_q;
    operand_t b_q;
    logic     valid_q;
    product_t p_core;

    // ======================================================================
    // Input stage
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q     <= '0;
            b_q     <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                a_q <= a;                              // Operands only move with a valid pair
                b_q <= b;
            end
        end
    end

    approx_mult_8x8 u_core (
        .a (a_q),
        .b (b_q),
        .p (p_core)
    );

    // ======================================================================
    // Output stage
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            p         <= '0;
        end else begin
            out_valid <= valid_q;
            if (valid_q) begin
                p <= p_core;                           // Holds its value through bubbles
            end
        end
    end

endmodule

// File: dv/approx_mult_tb.sv
`timescale 1ns/1ps

module approx_mult_tb
    import mult_geom_pkg::*;
    import approx_cfg_pkg::*;
();

    // ======================================================================
    // Run length and limits
    // ======================================================================
    localparam int          RESET_CYCLES   = 4;
    localparam int          DIR_N          = 13;
    localparam int          STREAM_N       = 200;
    localparam int          BUBBLE_N       = 100;
    localparam int          MAX_GAP        = 3;
    localparam int          DRAIN_CYCLES   = MULT_LATENCY + 2;
    localparam int          TAIL_IDLE      = 3;
    localparam int          STIM_CYCLES    = RESET_CYCLES + 1 + DIR_N + STREAM_N
                                           + BUBBLE_N * (MAX_GAP + 1) + 1 + 5 * DRAIN_CYCLES
                                           + TAIL_IDLE;
    localparam int          TIMEOUT_CYCLES = 2 * STIM_CYCLES + 20;
    localparam int unsigned RAND_SEED      = 32'h5d866d15;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    operand_t    a;
    operand_t    b;
    logic        out_valid;
    product_t    p;

    int          cyc = 0;
    product_t    last_p = '0;                          // Last value seen with out_valid high
    product_t    exp_q [$];
    string       tag_q [$];
    int          due_q [$];

    approx_mult_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .p         (p)
    );

    typedef struct packed {
        operand_t a;
        operand_t b;
        product_t p;
    } vector_t;

    // Expected products worked out by hand with the lower-OR rule
    vector_t dir_table [DIR_N] = '{
        '{8'd0,   8'd0,   16'd0},                      // Zero operands
        '{8'd0,   8'd255, 16'd0},
        '{8'd255, 8'd0,   16'd0},
        '{8'd1,   8'd1,   16'd1},
        '{8'd255, 8'd1,   16'd255},
        '{8'd1,   8'd128, 16'd128},                    // Powers of two stay exact
        '{8'd128, 8'd2,   16'd256},
        '{8'd16,  8'd16,  16'd256},
        '{8'd64,  8'd64,  16'd4096},
        '{8'd7,   8'd7,   16'd25},                     // OR zone swallows a carry
        '{8'd15,  8'd15,  16'd89},
        '{8'd100, 8'd200, 16'd19232},
        '{8'd255, 8'd255, 16'd63865}                   // All ones on both operands
    };

    // ======================================================================
    // Clock, cycle counter and timeout
    // ======================================================================
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout, run still going after %0d cycles", cyc));
        end
    end

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(string test, int expected, int actual);
        stop_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h", test, expected, actual));
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic int lower_or_add(int x, int y, int approx_bits);
        int low_mask;

        low_mask = (1 << approx_bits) - 1;
        return (((x >> approx_bits) + (y >> approx_bits)) << approx_bits) | ((x | y) & low_mask);
    endfunction

    // Carry out of the final adder is lost at every recursion level
    function automatic int combine_level(int p_hh, int p_hl, int p_lh, int p_ll, int hi_w,
                                         int split, int cross_approx, int sum_approx);
        int op1;
        int op2;
        int total;

        op1   = (p_hh << split) | (p_ll >> split);
        op2   = lower_or_add(p_hl, p_lh, cross_approx);
        total = lower_or_add(op1, op2, sum_approx) & ((1 << (2 * hi_w + split)) - 1);
        return (total << split) | (p_ll & ((1 << split) - 1));
    endfunction

    function automatic int model_5x5(int x, int y);
        int xh;
        int xl;
        int yh;
        int yl;

        xh = x >> SPLIT_5;
        yh = y >> SPLIT_5;
        xl = x & ((1 << SPLIT_5) - 1);
        yl = y & ((1 << SPLIT_5) - 1);
        return combine_level(xh * yh, xh * yl, xl * yh, xl * yl, OP3_W, SPLIT_5,
                             L5_CROSS_APPROX, L5_SUM_APPROX);
    endfunction

    function automatic int model_6x6(int x, int y);
        int xh;
        int xl;
        int yh;
        int yl;

        xh = x >> SPLIT_6;
        yh = y >> SPLIT_6;
        xl = x & ((1 << SPLIT_6) - 1);
        yl = y & ((1 << SPLIT_6) - 1);
        return combine_level(model_5x5(xh, yh), xh * yl, xl * yh, xl * yl, OP5_W, SPLIT_6,
                             L6_CROSS_APPROX, L6_SUM_APPROX);
    endfunction

    function automatic int model_8x8(int x, int y);
        int xh;
        int xl;
        int yh;
        int yl;

        xh = x >> SPLIT_8;
        yh = y >> SPLIT_8;
        xl = x & ((1 << SPLIT_8) - 1);
        yl = y & ((1 << SPLIT_8) - 1);
        return combine_level(model_6x6(xh, yh), xh * yl, xl * yh, xl * yl, OP6_W, SPLIT_8,
                             L8_CROSS_APPROX, L8_SUM_APPROX);
    endfunction

    // ======================================================================
    // Drivers and scoreboard
    // ======================================================================
    task automatic drive_pair(operand_t x, operand_t y, string tag);
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        exp_q.push_back(product_t'(model_8x8(int'(x), int'(y))));
        tag_q.push_back(tag);
        due_q.push_back(cyc + MULT_LATENCY);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        in_valid = 1'b0;
        a        = operand_t'($urandom());             // Garbage that must not be captured
        b        = operand_t'($urandom());
    endtask

    task automatic wait_drain();
        int n;

        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
            drive_idle();
            n++;
        end
    endtask

    task automatic check_output();
        product_t exp_p;
        string    tag;
        int       due;

        if (out_valid) begin
            assert (exp_q.size() != 0) else stop_run("out_valid was high with no pair in flight");
            exp_p = exp_q.pop_front();
            tag   = tag_q.pop_front();
            due   = due_q.pop_front();
            assert (cyc == due) else report_mismatch({tag, "_latency"}, due, cyc);
            assert (p == exp_p) else report_mismatch(tag, int'(exp_p), int'(p));
            last_p = p;
        end else begin
            assert (p == last_p) else report_mismatch("hold_in_gap", int'(last_p), int'(p));
            assert (exp_q.size() == 0 || due_q[0] > cyc) else
                stop_run($sformatf("result for %s did not come out on time", tag_q[0]));
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            check_output();
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int       waited;
        int       gap;
        operand_t ra;
        operand_t rb;

        void'($urandom(RAND_SEED));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!out_valid && p == '0) else stop_run("outputs not cleared during reset");
        end
        arst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && p == '0) else stop_run("outputs not cleared just after reset");

        for (int i = 0; i < DIR_N; i++) begin
            waited = model_8x8(int'(dir_table[i].a), int'(dir_table[i].b));
            assert (product_t'(waited) == dir_table[i].p) else
                report_mismatch($sformatf("table_vs_model_%0d", i), int'(dir_table[i].p), waited);
            drive_pair(dir_table[i].a, dir_table[i].b, $sformatf("directed_%0d", i));
        end
        wait_drain();

        drive_pair(8'd37, 8'd211, "single_pair");      // Lone pair into an empty pipeline
        waited = 0;
        while (!out_valid && waited < DRAIN_CYCLES) begin
            drive_idle();
            waited++;
        end
        assert (waited == MULT_LATENCY) else report_mismatch("latency", MULT_LATENCY, waited);
        wait_drain();

        for (int i = 0; i < STREAM_N; i++) begin
            ra = operand_t'($urandom());
            rb = operand_t'($urandom());
            drive_pair(ra, rb, $sformatf("stream_%0d", i));
        end
        wait_drain();

        for (int i = 0; i < BUBBLE_N; i++) begin
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) drive_idle();
            ra = operand_t'($urandom());
            rb = operand_t'($urandom());
            drive_pair(ra, rb, $sformatf("bubble_%0d", i));
        end
        wait_drain();
        repeat (TAIL_IDLE) drive_idle();               // Any stray out_valid shows up here

        if (exp_q.size() != 0) begin
            stop_run($sformatf("%0d results never came out of the pipeline", exp_q.size()));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
src/mult_geom_pkg.sv
src/approx_cfg_pkg.sv
src/lower_or_adder.sv
src/exact_sub_mult.sv
src/recursive_mult_5x5.sv
src/recursive_mult_6x6.sv
src/approx_mult_8x8.sv
src/approx_mult_top.sv
dv/approx_mult_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the approximate multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module approx_mult_tb \
    -f verilog.f \
    -o approx_mult_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/approx_mult_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
